// File: ex_stage.f
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_wb_select.sv
ex_stage.sv
tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
# Compile the execute stage and its testbench with Verilator, then run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_ex_stage -f ex_stage.f \
  && ./obj_dir/Vtb_ex_stage > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }

// File: tb_ex_stage.sv
/*
  Random-stimulus testbench for the integer execute stage
  A cycle model in the testbench predicts every DUT output
*/
`timescale 1ns/1ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int num_txn     = 1000;
  // Four cycles of 4 ns per transaction plus room for reset
  localparam int watchdog_ns = (num_txn * 4 + 200) * 4;

  logic                  clk;
  logic                  rst_n;
  alu_req_t              alu_req;
  mult_req_t             mult_req;
  logic                  alu_en;
  logic                  mult_en;
  logic                  csr_access;
  logic [xlen-1:0]       csr_rdata;
  logic                  lsu_en;
  logic [xlen-1:0]       lsu_rdata;
  logic                  lsu_ready_ex;
  logic                  lsu_err;
  logic                  branch_in_ex;
  logic                  wb_ready;
  logic                  regfile_alu_we;
  logic [reg_addr_w-1:0] regfile_alu_waddr;
  logic                  regfile_we;
  logic [reg_addr_w-1:0] regfile_waddr;
  wb_port_t              fw_port;
  wb_port_t              wb_port;
  logic [xlen-1:0]       jump_target;
  logic                  branch_decision;
  logic                  mult_multicycle;
  logic                  ex_ready;
  logic                  ex_valid;

  // Model state
  mult_state_e           m_state;
  logic [xlen-1:0]       m_high_word;
  logic                  m_wb_we;
  logic [reg_addr_w-1:0] m_wb_waddr;
  logic [31:0]           rng_state;

  ex_stage dut_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .mult_req_i          (mult_req),
    .mult_en_i           (mult_en),
    .mult_multicycle_o   (mult_multicycle),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .lsu_err_i           (lsu_err),
    .branch_in_ex_i      (branch_in_ex),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .fw_port_o           (fw_port),
    .wb_port_o           (wb_port),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid),
    .wb_ready_i          (wb_ready)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Random numbers and reference functions
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Branch and set-less-than flag from the RISC-V definitions
  function automatic logic expected_compare(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      alu_eq:             return a == b;
      alu_ne:             return a != b;
      alu_slt, alu_lt:    return $signed(a) < $signed(b);
      alu_sltu, alu_ltu:  return a < b;
      alu_ge:             return $signed(a) >= $signed(b);
      alu_geu:            return a >= b;
      default:            return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] expected_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or:  return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_sra: return $signed(a) >>> b[4:0];
      default: return {31'b0, expected_compare(op, a, b)};
    endcase
  endfunction

  // 64-bit product that wraps correctly for every signedness mix
  function automatic logic [63:0] full_product(mult_op_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    ext_a = {32'b0, a};
    ext_b = {32'b0, b};
    if (op == mult_mulh || op == mult_mulhsu) begin
      ext_a = {{32{a[31]}}, a};
    end
    if (op == mult_mulh) begin
      ext_b = {{32{b[31]}}, b};
    end
    return ext_a * ext_b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      report_failure($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Predict outputs for the current inputs, compare, then advance the model
  task automatic check_outputs();
    logic [63:0] prod;
    logic        high_op;
    logic        mult_ready;
    logic        units_ready;
    logic        exp_ready;
    logic        exp_valid;
    logic [31:0] mult_res;
    logic [31:0] fw_data;
    prod        = full_product(mult_req.operator, mult_req.operand_a, mult_req.operand_b);
    high_op     = mult_req.operator != mult_mul;
    // Only the first cycle of a high product stalls
    mult_ready  = !(m_state == idle && mult_en && high_op);
    mult_res    = (m_state == high_done) ? m_high_word : prod[31:0];
    units_ready = mult_ready & lsu_ready_ex & wb_ready;
    exp_ready   = units_ready | branch_in_ex;
    exp_valid   = (alu_en | mult_en | csr_access | lsu_en) & units_ready;
    // CSR, then multiplier, then ALU
    if (csr_access) begin
      fw_data = csr_rdata;
    end else if (mult_en) begin
      fw_data = mult_res;
    end else if (alu_en) begin
      fw_data = expected_alu(alu_req.operator, alu_req.operand_a, alu_req.operand_b);
    end else begin
      fw_data = '0;
    end

    check_value("fw_port_o.we", 32'(fw_port.we), 32'(regfile_alu_we));
    check_value("fw_port_o.waddr", 32'(fw_port.waddr), 32'(regfile_alu_waddr));
    check_value("fw_port_o.wdata", fw_port.wdata, fw_data);
    check_value("wb_port_o.we", 32'(wb_port.we), 32'(m_wb_we));
    check_value("wb_port_o.waddr", 32'(wb_port.waddr), 32'(m_wb_waddr));
    check_value("wb_port_o.wdata", wb_port.wdata, lsu_rdata);
    check_value("branch_decision_o", 32'(branch_decision),
                32'(expected_compare(alu_req.operator, alu_req.operand_a, alu_req.operand_b)));
    check_value("jump_target_o", jump_target, alu_req.operand_c);
    check_value("mult_multicycle_o", 32'(mult_multicycle), 32'(m_state == high_done));
    check_value("ex_ready_o", 32'(ex_ready), 32'(exp_ready));
    check_value("ex_valid_o", 32'(ex_valid), 32'(exp_valid));

    // Next state of the multiplier
    if (m_state == idle) begin
      if (mult_en && high_op) begin
        m_high_word = prod[63:32];
        m_state     = high_done;
      end
    end else if (exp_ready) begin
      m_state = idle;
    end
    // EX/WB register of the load/store port
    if (exp_valid) begin
      m_wb_we = regfile_we & ~lsu_err;
      if (m_wb_we) begin
        m_wb_waddr = regfile_waddr;
      end
    end else if (wb_ready) begin
      m_wb_we = 1'b0;
    end
  endtask

  // Check at the falling edge and drive the next inputs after the rise
  task automatic run_cycle();
    @(negedge clk);
    check_outputs();
    @(posedge clk);
    #0.5;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic run_transaction();
    logic [31:0] r;
    logic [31:0] r2;
    logic [3:0]  kind;
    int          hold;
    r    = lcg_next();
    r2   = lcg_next();
    kind = r[31:28];
    alu_req.operator   = alu_op_e'(r2[31:28]);
    alu_req.operand_a  = lcg_next();
    alu_req.operand_b  = lcg_next();
    alu_req.operand_c  = lcg_next();
    // Equal operands now and then so eq and ge see both outcomes
    if (r2[27:26] == 2'b00) begin
      alu_req.operand_b = alu_req.operand_a;
    end
    mult_req.operator  = mult_op_e'(r2[25:24]);
    mult_req.operand_a = lcg_next();
    mult_req.operand_b = lcg_next();
    csr_rdata          = lcg_next();
    lsu_rdata          = lcg_next();
    regfile_alu_we     = r[27];
    regfile_alu_waddr  = r[26:21];
    regfile_we         = r[20];
    regfile_waddr      = r[19:14];
    lsu_err            = (r[13:12] == 2'b00);
    lsu_ready_ex       = (r[11:9] != 3'b000);
    wb_ready           = (r[8:6] != 3'b000);
    lsu_en             = r[5];
    alu_en             = 1'b0;
    mult_en            = 1'b0;
    csr_access         = 1'b0;
    branch_in_ex       = 1'b0;

    if (kind < 4'd7) begin
      alu_en = 1'b1;
    end else if (kind < 4'd10) begin
      mult_en = 1'b1;
    end else if (kind == 4'd10) begin
      csr_access = 1'b1;
      alu_en     = 1'b1;
    end else if (kind == 4'd11) begin
      csr_access = 1'b1;
      mult_en    = 1'b1;
    end else if (kind < 4'd14) begin
      // Branch with writeback stalled half of the time
      alu_en       = 1'b1;
      branch_in_ex = 1'b1;
      wb_ready     = r[4];
    end else if (kind == 4'd14) begin
      lsu_en = 1'b1;
    end
    run_cycle();

    // Hold the request while a high product waits to leave
    hold = 0;
    while (m_state == high_done) begin
      hold = hold + 1;
      r            = lcg_next();
      wb_ready     = r[31] | (hold > 3);
      lsu_ready_ex = 1'b1;
      run_cycle();
    end
  endtask

  initial begin
    clk               = 1'b0;
    rst_n             = 1'b0;
    rng_state         = 32'h2769f445;
    alu_req           = '0;
    mult_req          = '0;
    alu_en            = 1'b0;
    mult_en           = 1'b0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    m_state           = idle;
    m_high_word       = '0;
    m_wb_we           = 1'b0;
    m_wb_waddr        = '0;
    repeat (10) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    for (int i = 0; i < num_txn; i++) begin
      run_transaction();
    end
    $display("all tests passed");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    report_failure("simulation timed out before all transactions completed");
  end

endmodule

// File: ex_stage.sv
/*
  Integer execute stage top level
  ALU, multiplier, write ports, branch outputs and the stall handshake
*/
`timescale 1ns/1ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,

  // ALU request from decode
  input  ex_pkg::alu_req_t              alu_req_i,
  input  logic                          alu_en_i,

  // Multiplier request from decode
  input  ex_pkg::mult_req_t             mult_req_i,
  input  logic                          mult_en_i,
  output logic                          mult_multicycle_o,

  // CSR read data for the forwarding port
  input  logic                          csr_access_i,
  input  logic [ex_pkg::xlen-1:0]       csr_rdata_i,

  // Load/store unit
  input  logic                          lsu_en_i,
  input  logic [ex_pkg::xlen-1:0]       lsu_rdata_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,

  input  logic                          branch_in_ex_i,

  // Forwarding port destination
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_alu_waddr_i,

  // Load/store port destination, passed on to writeback
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_waddr_i,

  // Register-file write ports
  output ex_pkg::wb_port_t              fw_port_o,
  output ex_pkg::wb_port_t              wb_port_o,

  // Branch resolution toward fetch
  output logic [ex_pkg::xlen-1:0]       jump_target_o,
  output logic                          branch_decision_o,

  // Stall handshake
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  input  logic                          wb_ready_i
);

  import ex_pkg::*;

  logic [xlen-1:0] alu_result;
  logic            alu_cmp_result;
  logic [xlen-1:0] mult_result;
  logic            mult_ready;
  logic            units_ready;

  //////////////////////////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (mult_en_i),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_select wb_sel_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .alu_en_i      (alu_en_i),
    .mult_en_i     (mult_en_i),
    .csr_access_i  (csr_access_i),
    .alu_we_i      (regfile_alu_we_i),
    .alu_waddr_i   (regfile_alu_waddr_i),
    .lsu_we_i      (regfile_we_i),
    .lsu_waddr_i   (regfile_waddr_i),
    .lsu_err_i     (lsu_err_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .ex_valid_i    (ex_valid_o),
    .wb_ready_i    (wb_ready_i),
    .fw_port_o     (fw_port_o),
    .wb_port_o     (wb_port_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Branch outputs and handshake
  //////////////////////////////////////////////////////////////////////

  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_req_i.operand_c;

  // Every unit that can hold the stage, plus writeback back-pressure
  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here and never wait on writeback
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid flows forward on its own, independent of ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // Both units feed the same forwarding slot
  alu_mult_exclusive_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(alu_en_i && mult_en_i)
  ) else $error("ALU and multiplier enabled in the same cycle");

endmodule

// File: ex_wb_select.sv
/*
  Register-file write ports of the execute stage
  Forwarding-port mux and the EX/WB register of the load/store port
*/
`timescale 1ns/1ps

module ex_wb_select (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [ex_pkg::xlen-1:0]       alu_result_i,
  input  logic [ex_pkg::xlen-1:0]       mult_result_i,
  input  logic [ex_pkg::xlen-1:0]       csr_rdata_i,
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  input  logic                          csr_access_i,
  input  logic                          alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] alu_waddr_i,
  input  logic                          lsu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] lsu_waddr_i,
  input  logic                          lsu_err_i,
  input  logic [ex_pkg::xlen-1:0]       lsu_rdata_i,
  input  logic                          ex_valid_i,
  input  logic                          wb_ready_i,
  output ex_pkg::wb_port_t              fw_port_o,
  output ex_pkg::wb_port_t              wb_port_o
);

  import ex_pkg::*;

  logic                  lsu_we_ok;
  logic                  lsu_we_q;
  logic [reg_addr_w-1:0] lsu_waddr_q;

  //////////////////////////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fw_port_o.we    = alu_we_i;
    fw_port_o.waddr = alu_waddr_i;
    // CSR wins over the multiplier, which wins over the ALU
    if (csr_access_i) begin
      fw_port_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_port_o.wdata = alu_result_i;
    end else begin
      fw_port_o.wdata = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Load/store port, EX/WB register
  //////////////////////////////////////////////////////////////////////

  // A faulting access must not reach the register file
  assign lsu_we_ok = lsu_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_i) begin
      lsu_we_q <= lsu_we_ok;
      if (lsu_we_ok) begin
        lsu_waddr_q <= lsu_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new from EX, so drain the write
      lsu_we_q <= 1'b0;
    end
  end

  // Load data arrives during writeback, so it is not registered here
  assign wb_port_o.we    = lsu_we_q;
  assign wb_port_o.waddr = lsu_waddr_q;
  assign wb_port_o.wdata = lsu_rdata_i;

  wb_we_known_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(wb_port_o.we)
  ) else $error("Load/store write enable is unknown");

endmodule

// File: ex_mult.sv
/*
  Integer multiplier for the execute stage
  MUL answers in one cycle and the high-product forms take a second cycle
*/
`timescale 1ns/1ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    en_i,
  input  ex_pkg::mult_req_t       req_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::xlen-1:0] result_o,
  output logic                    ready_o,
  output logic                    multicycle_o
);

  import ex_pkg::*;

  logic                      sign_a;
  logic                      sign_b;
  logic                      high_op;
  logic signed [xlen:0]      op_a_ext;
  logic signed [xlen:0]      op_b_ext;
  logic signed [2*xlen+1:0]  product;
  logic [2*xlen-1:0]         product_q;
  mult_state_e               state_q;
  mult_state_e               state_d;

  //////////////////////////////////////////////////////////////////////
  // Operand extension and product
  //////////////////////////////////////////////////////////////////////

  // MULHSU treats only operand a as signed
  assign sign_a  = (req_i.operator == mult_mulh) || (req_i.operator == mult_mulhsu);
  assign sign_b  = (req_i.operator == mult_mulh);
  assign high_op = (req_i.operator != mult_mul);

  // Extra sign bit on each operand lets one signed multiply cover every signedness mix
  assign op_a_ext = {sign_a & req_i.operand_a[xlen-1], req_i.operand_a};
  assign op_b_ext = {sign_b & req_i.operand_b[xlen-1], req_i.operand_b};

  // Both 33-bit operands sign extended to the full product width
  assign product = $signed({{(xlen+1){op_a_ext[xlen]}}, op_a_ext}) *
                   $signed({{(xlen+1){op_b_ext[xlen]}}, op_b_ext});

  // Captured on the first cycle of a high-product request
  always_ff @(posedge clk) begin
    if ((state_q == idle) && en_i && high_op) begin
      product_q <= product[2*xlen-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    // Low word goes straight out for MUL
    result_o     = product[xlen-1:0];

    case (state_q)
      idle: begin
        // Stall the stage for one cycle while the product is registered
        if (en_i && high_op) begin
          ready_o = 1'b0;
          state_d = high_done;
        end
      end
      high_done: begin
        multicycle_o = 1'b1;
        result_o     = product_q[2*xlen-1:xlen];
        // Stay here until the stage can hand the result on
        if (ex_ready_i) begin
          state_d = idle;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Decode must hold the request while the high word waits on a stall
  mult_req_stable_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == high_done && !ex_ready_i) |=> $stable(req_i)
  ) else $error("Multiplier request changed during a stalled high product");

endmodule

// File: ex_alu.sv
/*
  Execute-stage ALU, purely combinational
  Arithmetic, logic, shifts, set-less-than and the branch comparator
*/
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_req_t        req_i,
  output logic [ex_pkg::xlen-1:0] result_o,
  output logic                    cmp_result_o
);

  import ex_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            cmp_signed;
  logic [xlen:0]   diff;
  logic            is_lt;
  logic            is_eq;
  logic [xlen-1:0] add_res;
  logic [xlen-1:0] sra_res;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  // RV32 shifts only look at the low five bits
  assign shamt = op_b[4:0];

  //////////////////////////////////////////////////////////////////////
  // Shared subtractor
  //////////////////////////////////////////////////////////////////////

  // Signed compares extend with the sign bit, unsigned ones with zero
  assign cmp_signed = (req_i.operator == alu_slt) ||
                      (req_i.operator == alu_lt)  ||
                      (req_i.operator == alu_ge);

  // One extra bit so the borrow out gives less-than directly
  assign diff = {cmp_signed & op_a[xlen-1], op_a} -
                {cmp_signed & op_b[xlen-1], op_b};

  assign is_lt = diff[xlen];
  // Zero difference means equal operands, whatever the extension
  assign is_eq = (diff == '0);

  assign add_res = op_a + op_b;
  // Arithmetic shift keeps the sign of operand a
  assign sra_res = $signed(op_a) >>> shamt;

  //////////////////////////////////////////////////////////////////////
  // Compare result
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.operator)
      alu_eq: begin
        cmp_result_o = is_eq;
      end
      alu_ne: begin
        cmp_result_o = ~is_eq;
      end
      // Set-less-than reuses the branch less-than
      alu_lt, alu_ltu, alu_slt, alu_sltu: begin
        cmp_result_o = is_lt;
      end
      alu_ge, alu_geu: begin
        cmp_result_o = ~is_lt;
      end
      default: begin
        cmp_result_o = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.operator)
      alu_add: result_o = add_res;
      // Low word of the shared subtractor
      alu_sub: result_o = diff[xlen-1:0];
      alu_and: result_o = op_a & op_b;
      alu_or:  result_o = op_a | op_b;
      alu_xor: result_o = op_a ^ op_b;
      alu_sll: result_o = op_a << shamt;
      alu_srl: result_o = op_a >> shamt;
      alu_sra: result_o = sra_res;
      // Compares return the flag zero extended
      default: begin
        result_o = {{(xlen-1){1'b0}}, cmp_result_o};
      end
    endcase
  end

endmodule

// File: ex_pkg.sv
/*
  Shared types and widths for the integer execute stage
  Operation encodings, unit request bundles and register-file write ports
*/
package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Datapath word
  localparam int unsigned xlen       = 32;
  // Register address, wide enough for the extended register file
  localparam int unsigned reg_addr_w = 6;

  //////////////////////////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////////////////////////

  // ALU operations, compares share the upper half of the encoding
  typedef enum logic [3:0] {
    alu_add  = 4'h0,
    alu_sub  = 4'h1,
    alu_and  = 4'h2,
    alu_or   = 4'h3,
    alu_xor  = 4'h4,
    alu_sll  = 4'h5,
    alu_srl  = 4'h6,
    alu_sra  = 4'h7,
    alu_slt  = 4'h8,
    alu_sltu = 4'h9,
    alu_eq   = 4'ha,
    alu_ne   = 4'hb,
    alu_lt   = 4'hc,
    alu_ge   = 4'hd,
    alu_ltu  = 4'he,
    alu_geu  = 4'hf
  } alu_op_e;

  // Multiplier operations
  // Only mul returns the low word, the others want the high half
  typedef enum logic [1:0] {
    mult_mul    = 2'd0,
    mult_mulh   = 2'd1,
    mult_mulhsu = 2'd2,
    mult_mulhu  = 2'd3
  } mult_op_e;

  // High-product sequencing in the multiplier
  typedef enum logic {
    idle      = 1'b0,
    high_done = 1'b1
  } mult_state_e;

  //////////////////////////////////////////////////////////////////////
  // Request and write-port bundles
  //////////////////////////////////////////////////////////////////////

  // Operand c carries the jump target
  typedef struct packed {
    alu_op_e         operator;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] operand_c;
  } alu_req_t;

  typedef struct packed {
    mult_op_e        operator;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
  } mult_req_t;

  // One register-file write port
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } wb_port_t;

endpackage
